// File: tests/insn_fetch_trace.txt
// Fetch trace, all values hex. Image at @000, one stored word per word address (check 38:32, insn 31:0)
// Rows at @400, one per cycle: req_valid req_addr clear prefetch_en loop_active loop_iterations
// loop_end loop_jump ignore_errs, then expected imem_addr resp_valid resp_addr resp_data fetch_err addr_err
@000
6c00000013 // 0x000
2c00100013 // 0x004
6d00200013 // 0x008
2d00300013 // 0x00c
6e00400013 // 0x010
1c00000063 // 0x014 branch
2e00500013 // 0x018
6f00600013 // 0x01c
2f00700013 // 0x020
6800800013 // 0x024
2800900093 // 0x028 bit 7 flipped, check bits belong to 00900013
@400
// Sequential fetch
0 000 0 1 0 0 000 000 0  000 0 000 00000000 0 0
1 000 0 1 0 0 000 000 0  004 0 000 00000000 0 0
1 004 0 1 0 0 000 000 0  008 1 000 00000013 0 0
1 008 0 1 0 0 000 000 0  00c 1 004 00100013 0 0
// Stall and clear
0 000 0 1 0 0 000 000 0  00c 1 008 00200013 0 0
0 000 1 1 0 0 000 000 0  00c 1 008 00200013 0 0
0 000 0 1 0 0 000 000 0  00c 0 008 00200013 0 0
1 00c 0 1 0 0 000 000 0  010 0 008 00200013 0 0
// Redirect to 0x020
1 020 0 1 0 0 000 000 0  020 1 00c 00300013 0 1
1 020 0 1 0 0 000 000 0  024 0 00c 00300013 0 0
1 024 0 1 0 0 000 000 0  028 1 020 00700013 0 0
1 028 0 1 0 0 000 000 0  02c 1 024 00800013 0 0
// Corrupted word is the response, then a mismatch with errors ignored
0 000 0 1 0 0 000 000 0  02c 1 028 00900093 1 0
1 000 0 1 0 0 000 000 1  000 1 028 00900093 1 0
1 000 0 1 0 0 000 000 0  004 0 028 00900093 0 0
// Branch stop at 0x014
1 010 0 1 0 0 000 000 0  010 1 000 00000013 0 1
1 010 0 1 0 0 000 000 0  014 0 000 00000013 0 0
1 014 0 1 0 0 000 000 0  018 1 010 00400013 0 0
1 018 0 1 0 0 000 000 0  018 1 014 00000063 0 0
1 018 0 1 0 0 000 000 0  01c 0 014 00000063 0 0
// Loop from 0x018 to 0x020, two passes
1 01c 0 1 1 2 020 018 0  020 1 018 00500013 0 0
1 020 0 1 1 2 020 018 0  018 1 01c 00600013 0 0
1 018 0 1 1 1 020 018 0  01c 1 020 00700013 0 0
1 01c 0 1 1 1 020 018 0  020 1 018 00500013 0 0
1 020 0 1 1 1 020 018 0  024 1 01c 00600013 0 0
1 024 0 1 0 0 000 000 0  028 1 020 00700013 0 0
// Clear, then prefetch off for one cycle
0 000 1 1 0 0 000 000 0  028 1 024 00800013 0 0
0 000 0 0 0 0 000 000 0  028 0 024 00800013 0 0
0 000 0 1 0 0 000 000 0  028 0 024 00800013 0 0

// File: insn_fetch.f
+incdir+common
common/isa_pkg.sv
common/fetch_pkg.sv
common/prefetch_if.sv
hw/insn_intg_check.sv
hw/insn_fetch/prefetch_ctrl.sv
hw/insn_fetch/fetch_resp_stage.sv
hw/insn_fetch/insn_fetch_top.sv
tests/tb_insn_fetch.sv

// File: Makefile
# Verilator build and run of the instruction fetch testbench
TOP := tb_insn_fetch
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f insn_fetch.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "sim passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: tests/tb_insn_fetch.sv
//////////////////////////////////////////////////
// Instruction fetch testbench
// Plays a per-cycle trace against the fetch unit
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module tb_insn_fetch import isa_pkg::*, fetch_pkg::*; ();

  // Word slots of the memory image, then room for the cycle rows
  localparam int MEM_WORDS   = `IMEM_SIZE_BYTE / 4;
  localparam int ROW_BASE    = MEM_WORDS;
  localparam int ROW_FIELDS  = 15;
  localparam int TRACE_DEPTH = 2 * MEM_WORDS;
  localparam int MAX_ROWS    = (TRACE_DEPTH - ROW_BASE) / ROW_FIELDS;

  logic        clk_i;
  logic        rst_ni;
  logic        imem_req;
  imem_addr_t  imem_addr;
  insn_intg_t  imem_rdata;
  logic        imem_rvalid;
  logic        req_valid;
  imem_addr_t  req_addr;
  logic        resp_valid;
  imem_addr_t  resp_addr;
  insn_t       resp_data;
  logic        resp_clear;
  logic        pf_en;
  logic        loop_active;
  logic [31:0] loop_iterations;
  loop_end_t   loop_end;
  imem_addr_t  loop_jump;
  logic        ignore_errs;
  logic        fetch_err;
  logic        addr_err;

  logic [39:0] trace_data [0:TRACE_DEPTH-1];
  insn_intg_t  mem [0:MEM_WORDS-1];
  int          n_rows;
  int          row_idx;
  int          cycle_cnt = 0;
  int          cycle_limit;

  insn_fetch_top i_dut (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .imem_req_o                 (imem_req),
    .imem_addr_o                (imem_addr),
    .imem_rdata_i               (imem_rdata),
    .imem_rvalid_i              (imem_rvalid),
    .insn_fetch_req_valid_i     (req_valid),
    .insn_fetch_req_addr_i      (req_addr),
    .insn_fetch_resp_valid_o    (resp_valid),
    .insn_fetch_resp_addr_o     (resp_addr),
    .insn_fetch_resp_data_o     (resp_data),
    .insn_fetch_resp_clear_i    (resp_clear),
    .prefetch_en_i              (pf_en),
    .prefetch_loop_active_i     (loop_active),
    .prefetch_loop_iterations_i (loop_iterations),
    .prefetch_loop_end_addr_i   (loop_end),
    .prefetch_loop_jump_addr_i  (loop_jump),
    .prefetch_ignore_errs_i     (ignore_errs),
    .insn_fetch_err_o           (fetch_err),
    .insn_addr_err_o            (addr_err)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Memory answers every request one cycle later
  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      imem_rvalid <= 1'b0;
      imem_rdata  <= '0;
    end else begin
      imem_rvalid <= imem_req;
      if (imem_req) begin
        imem_rdata <= mem[imem_addr[`IMEM_ADDR_W-1:2]];
      end
    end
  end

  // Low two address bits are zero, so no fill word decodes as a control transfer
  function automatic insn_intg_t fill_word(input int w);
    imem_addr_t byte_addr;
    byte_addr = imem_addr_t'(w * 4);
    return {7'h2a, 8'hc3, byte_addr, byte_addr};
  endfunction

  task automatic stop_on_failure();
    $display("sim failed");
    $fatal(1);
  endtask

  task automatic check_addr(input string name, input imem_addr_t got, input imem_addr_t exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: row %0d %s is %h, expected %h",
               $time, row_idx, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_insn(input string name, input insn_t got, input insn_t exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: row %0d %s is %h, expected %h",
               $time, row_idx, name, got, exp);
      stop_on_failure();
    end
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch at time %0t: row %0d %s is %b, expected %b",
               $time, row_idx, name, got, exp);
      stop_on_failure();
    end
  endtask

  // Fill first, so the image only overrides the words it names
  task automatic load_trace();
    for (int w = 0; w < MEM_WORDS; w++) begin
      trace_data[w] = {1'b0, fill_word(w)};
    end
    for (int i = ROW_BASE; i < TRACE_DEPTH; i++) begin
      trace_data[i] = '1;
    end
    $readmemh("tests/insn_fetch_trace.txt", trace_data);
    for (int w = 0; w < MEM_WORDS; w++) begin
      mem[w] = trace_data[w][`INSN_INTG_W-1:0];
    end
    n_rows = 0;
    while (n_rows < MAX_ROWS && trace_data[ROW_BASE + n_rows * ROW_FIELDS] != '1) begin
      n_rows++;
    end
  endtask

  task automatic apply_row(input int base);
    req_valid       = trace_data[base][0];
    req_addr        = trace_data[base + 1][`IMEM_ADDR_W-1:0];
    resp_clear      = trace_data[base + 2][0];
    pf_en           = trace_data[base + 3][0];
    loop_active     = trace_data[base + 4][0];
    loop_iterations = trace_data[base + 5][31:0];
    loop_end        = trace_data[base + 6][`IMEM_ADDR_W:0];
    loop_jump       = trace_data[base + 7][`IMEM_ADDR_W-1:0];
    ignore_errs     = trace_data[base + 8][0];
  endtask

  task automatic check_row(input int base);
    // The memory request follows the prefetch enable of the same row
    check_flag("imem_req_o", imem_req, trace_data[base + 3][0]);
    check_addr("imem_addr_o", imem_addr, trace_data[base + 9][`IMEM_ADDR_W-1:0]);
    check_flag("insn_fetch_resp_valid_o", resp_valid, trace_data[base + 10][0]);
    check_addr("insn_fetch_resp_addr_o", resp_addr, trace_data[base + 11][`IMEM_ADDR_W-1:0]);
    check_insn("insn_fetch_resp_data_o", resp_data, trace_data[base + 12][`INSN_W-1:0]);
    check_flag("insn_fetch_err_o", fetch_err, trace_data[base + 13][0]);
    check_flag("insn_addr_err_o", addr_err, trace_data[base + 14][0]);
  endtask

  // Reset cycles and the trace rows, plus some slack
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= cycle_limit) begin
      $display("timeout: the trace did not finish within %0d cycles", cycle_limit);
      stop_on_failure();
    end
  end

  initial begin
    rst_ni          = 1'b0;
    req_valid       = 1'b0;
    req_addr        = '0;
    resp_clear      = 1'b0;
    pf_en           = 1'b0;
    loop_active     = 1'b0;
    loop_iterations = '0;
    loop_end        = '0;
    loop_jump       = '0;
    ignore_errs     = 1'b0;
    row_idx         = 0;
    load_trace();
    cycle_limit = n_rows + 16 + 20;
    if (n_rows == 0) begin
      $display("the trace file holds no stimulus rows");
      stop_on_failure();
    end
    repeat (16) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    // Each row is driven just after an edge and checked at the falling edge
    for (int r = 0; r < n_rows; r++) begin
      row_idx = r;
      apply_row(ROW_BASE + r * ROW_FIELDS);
      @(negedge clk_i);
      check_row(ROW_BASE + r * ROW_FIELDS);
      @(posedge clk_i);
      #2;
    end
    $display("sim passed");
    $finish;
  end

endmodule

// File: hw/insn_fetch/insn_fetch_top.sv
//////////////////////////////////////////////////
// Instruction fetch unit
// Prefetch, response register and integrity check
//////////////////////////////////////////////////
`timescale 1ns/1ps

module insn_fetch_top import isa_pkg::*, fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  // Instruction memory, read only
  output logic        imem_req_o,
  output imem_addr_t  imem_addr_o,
  input  insn_intg_t  imem_rdata_i,
  input  logic        imem_rvalid_i,

  // Fetch request from the execute side
  input  logic        insn_fetch_req_valid_i,
  input  imem_addr_t  insn_fetch_req_addr_i,

  // Fetched instruction
  output logic        insn_fetch_resp_valid_o,
  output imem_addr_t  insn_fetch_resp_addr_o,
  output insn_t       insn_fetch_resp_data_o,
  input  logic        insn_fetch_resp_clear_i,

  // Prefetch control from the controller
  input  logic        prefetch_en_i,
  input  logic        prefetch_loop_active_i,
  input  logic [31:0] prefetch_loop_iterations_i,
  input  loop_end_t   prefetch_loop_end_addr_i,
  input  imem_addr_t  prefetch_loop_jump_addr_i,
  input  logic        prefetch_ignore_errs_i,

  // Fault reporting
  output logic        insn_fetch_err_o,
  output logic        insn_addr_err_o
);

  // Registered word sent back to the check
  insn_intg_t resp_word;
  logic       intg_err;

  // Prefetched word between the controller and the response stage
  prefetch_if pf ();

  prefetch_ctrl i_prefetch_ctrl (
    .clk_i                      (clk_i),
    .rst_ni                     (rst_ni),
    .imem_rdata_i               (imem_rdata_i),
    .imem_rvalid_i              (imem_rvalid_i),
    .insn_fetch_req_valid_i     (insn_fetch_req_valid_i),
    .insn_fetch_req_addr_i      (insn_fetch_req_addr_i),
    .prefetch_en_i              (prefetch_en_i),
    .prefetch_loop_active_i     (prefetch_loop_active_i),
    .prefetch_loop_iterations_i (prefetch_loop_iterations_i),
    .prefetch_loop_end_addr_i   (prefetch_loop_end_addr_i),
    .prefetch_loop_jump_addr_i  (prefetch_loop_jump_addr_i),
    .imem_req_o                 (imem_req_o),
    .imem_addr_o                (imem_addr_o),
    .pf                         (pf.ctrl)
  );

  fetch_resp_stage i_fetch_resp_stage (
    .clk_i                   (clk_i),
    .rst_ni                  (rst_ni),
    .insn_fetch_req_valid_i  (insn_fetch_req_valid_i),
    .insn_fetch_req_addr_i   (insn_fetch_req_addr_i),
    .insn_fetch_resp_clear_i (insn_fetch_resp_clear_i),
    .prefetch_ignore_errs_i  (prefetch_ignore_errs_i),
    .intg_err_i              (intg_err),
    .insn_fetch_resp_valid_o (insn_fetch_resp_valid_o),
    .insn_fetch_resp_addr_o  (insn_fetch_resp_addr_o),
    .insn_fetch_resp_data_o  (insn_fetch_resp_data_o),
    .resp_word_o             (resp_word),
    .insn_fetch_err_o        (insn_fetch_err_o),
    .insn_addr_err_o         (insn_addr_err_o),
    .pf                      (pf.resp)
  );

  // Check runs on the registered word, not on the memory bus
  insn_intg_check i_insn_intg_check (
    .word_i (resp_word),
    .err_o  (intg_err)
  );

endmodule

// File: hw/insn_fetch/fetch_resp_stage.sv
//////////////////////////////////////////////////
// Fetch response stage
// Response registers, error gating and address fault
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module fetch_resp_stage import isa_pkg::*, fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  logic        insn_fetch_req_valid_i,
  input  imem_addr_t  insn_fetch_req_addr_i,
  input  logic        insn_fetch_resp_clear_i,
  input  logic        prefetch_ignore_errs_i,
  input  logic        intg_err_i,

  output logic        insn_fetch_resp_valid_o,
  output imem_addr_t  insn_fetch_resp_addr_o,
  output insn_t       insn_fetch_resp_data_o,
  output insn_intg_t  resp_word_o,
  output logic        insn_fetch_err_o,
  output logic        insn_addr_err_o,

  prefetch_if.resp    pf
);

  logic       resp_valid_q;
  logic       resp_valid_d;
  logic       resp_load;
  imem_addr_t resp_addr_q;
  insn_intg_t resp_word_q;

  // Only a request that hits the prefetched word loads the response
  assign resp_load = insn_fetch_req_valid_i & pf.pf_hit;

  // A request decides validity on its own, otherwise hold until cleared
  assign resp_valid_d = insn_fetch_req_valid_i ? pf.pf_hit :
                                                 resp_valid_q & ~insn_fetch_resp_clear_i;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_valid_q <= 1'b0;
    end else begin
      resp_valid_q <= resp_valid_d;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_addr_q <= '0;
      resp_word_q <= '0;
    end else if (resp_load) begin
      resp_addr_q <= pf.pf_addr;
      resp_word_q <= pf.pf_rdata;
    end
  end

  assign insn_fetch_resp_valid_o = resp_valid_q;
  assign insn_fetch_resp_addr_o  = resp_addr_q;
  // Check bits are stripped before the word goes to the decoder
  assign insn_fetch_resp_data_o  = resp_word_q[`INSN_W-1:0];
  assign resp_word_o             = resp_word_q;

  // A stale word in the register must not report an error
  assign insn_fetch_err_o = intg_err_i & resp_valid_q;

  // The prefetcher is either right or has nothing, so a valid word at the
  // wrong address points at a fault in the control flow
  assign insn_addr_err_o = pf.pf_rvalid & insn_fetch_req_valid_i & ~prefetch_ignore_errs_i &
                           (insn_fetch_req_addr_i != pf.pf_addr);

  a_addr_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !resp_load |=> $stable(resp_addr_q));

endmodule

// File: hw/insn_fetch/prefetch_ctrl.sv
//////////////////////////////////////////////////
// Prefetch controller
// Picks the next memory address and tracks the kill
//////////////////////////////////////////////////
`timescale 1ns/1ps

module prefetch_ctrl import isa_pkg::*, fetch_pkg::*; (
  input  logic        clk_i,
  input  logic        rst_ni,

  input  insn_intg_t  imem_rdata_i,
  input  logic        imem_rvalid_i,

  input  logic        insn_fetch_req_valid_i,
  input  imem_addr_t  insn_fetch_req_addr_i,

  input  logic        prefetch_en_i,
  input  logic        prefetch_loop_active_i,
  input  logic [31:0] prefetch_loop_iterations_i,
  input  loop_end_t   prefetch_loop_end_addr_i,
  input  imem_addr_t  prefetch_loop_jump_addr_i,

  output logic        imem_req_o,
  output imem_addr_t  imem_addr_o,

  prefetch_if.ctrl    pf
);

  imem_addr_t pf_addr_q;
  logic       kill_q;
  logic       kill_d;
  logic       pf_rvalid;
  logic       pf_hit;
  logic       pf_capture;
  logic       is_branch;
  logic       loop_end_hit;
  opcode_e    opcode;
  pf_sel_e    pf_sel;

  // A killed word is treated as if memory had not answered
  assign pf_rvalid = imem_rvalid_i & ~kill_q;
  assign pf_hit    = pf_rvalid & (insn_fetch_req_addr_i == pf_addr_q);

  // Any control transfer stops prefetching since its target is unknown here
  assign opcode    = opcode_e'(imem_rdata_i[6:0]);
  assign is_branch = opcode inside {OPC_BRANCH, OPC_JAL, OPC_JALR};

  // Jump back only if at least one more pass of the loop follows
  assign loop_end_hit = prefetch_loop_active_i &&
                        ({1'b0, pf_addr_q} == prefetch_loop_end_addr_i) &&
                        (prefetch_loop_iterations_i > 32'd1);

  // Address choice in priority order
  always_comb begin
    if (!insn_fetch_req_valid_i) begin
      pf_sel = PF_HOLD;
    end else if (!pf_hit) begin
      pf_sel = PF_REDIRECT;
    end else if (is_branch) begin
      pf_sel = PF_BRANCH_STOP;
    end else if (loop_end_hit) begin
      pf_sel = PF_LOOP;
    end else begin
      pf_sel = PF_NEXT;
    end
  end

  always_comb begin
    unique case (pf_sel)
      // Stalled requester will want the same word again
      PF_HOLD:     imem_addr_o = pf_addr_q;
      PF_REDIRECT: imem_addr_o = insn_fetch_req_addr_i;
      PF_LOOP:     imem_addr_o = prefetch_loop_jump_addr_i;
      // Branch stop leaves the sequential address on the bus but drops the answer
      default:     imem_addr_o = pf_addr_q + imem_addr_t'(4);
    endcase
  end

  assign kill_d     = (pf_sel == PF_BRANCH_STOP);
  assign pf_capture = prefetch_en_i & ~kill_d;
  assign imem_req_o = prefetch_en_i;

  // The captured address is the one whose data arrives next cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      pf_addr_q <= '0;
    end else if (pf_capture) begin
      pf_addr_q <= imem_addr_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      kill_q <= 1'b0;
    end else begin
      kill_q <= kill_d;
    end
  end

  assign pf.pf_addr   = pf_addr_q;
  assign pf.pf_rvalid = pf_rvalid;
  assign pf.pf_rdata  = imem_rdata_i;
  assign pf.pf_hit    = pf_hit;

  // Word handed to the response stage was really returned by memory
  a_rvalid_from_mem: assert property (@(posedge clk_i) disable iff (!rst_ni)
    pf_rvalid |-> imem_rvalid_i);

  // A kill forces a miss next cycle, so a held request can never stop twice
  a_no_double_kill: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (kill_d && insn_fetch_req_valid_i) ##1 insn_fetch_req_valid_i |-> !kill_d);

endmodule

// File: hw/insn_intg_check.sv
//////////////////////////////////////////////////
// Instruction integrity check
// Recomputes the 7 check bits and flags a mismatch
//////////////////////////////////////////////////
`timescale 1ns/1ps
`include "fetch_params.svh"

module insn_intg_check import isa_pkg::*; (
  input  insn_intg_t word_i,
  output logic       err_o
);

  intg_t calc_intg;

  // Check bit k is the inverted parity of data bits with index mod 7 equal to k
  always_comb begin
    calc_intg = '1;
    for (int i = 0; i < `INSN_W; i++) begin
      calc_intg[i % `INTG_W] = calc_intg[i % `INTG_W] ^ word_i[i];
    end
  end

  // Any differing bit counts, there is no correction
  assign err_o = |(calc_intg ^ word_i[`INSN_INTG_W-1:`INSN_W]);

endmodule

// File: common/prefetch_if.sv
//////////////////////////////////////////////////
// Prefetch interface
// Carries the prefetched word to the response stage
//////////////////////////////////////////////////
`timescale 1ns/1ps

interface prefetch_if import isa_pkg::*, fetch_pkg::*; ();

  // Address of the word now on the memory data bus
  imem_addr_t pf_addr;
  // Memory rvalid after the kill has been applied
  logic       pf_rvalid;
  // Stored word with its check bits
  insn_intg_t pf_rdata;
  // Valid prefetch whose address matches the request
  logic       pf_hit;

  // The prefetch controller drives every signal
  modport ctrl (
    output pf_addr,
    output pf_rvalid,
    output pf_rdata,
    output pf_hit
  );

  // The response stage only samples them
  modport resp (
    input pf_addr,
    input pf_rvalid,
    input pf_rdata,
    input pf_hit
  );

endinterface

// File: common/fetch_pkg.sv
//////////////////////////////////////////////////
// Fetch package
// Address types and the prefetch address choice
//////////////////////////////////////////////////
`include "fetch_params.svh"

package fetch_pkg;

  // Byte address into instruction memory
  typedef logic [`IMEM_ADDR_W-1:0] imem_addr_t;

  // One extra bit so a loop end past memory never matches
  typedef logic [`IMEM_ADDR_W:0] loop_end_t;

  // Source of the next prefetch address
  typedef enum logic [2:0] {
    PF_NEXT,
    PF_HOLD,
    PF_REDIRECT,
    PF_BRANCH_STOP,
    PF_LOOP
  } pf_sel_e;

endpackage

// File: common/isa_pkg.sv
//////////////////////////////////////////////////
// ISA package
// Opcodes and instruction word types
//////////////////////////////////////////////////
`include "fetch_params.svh"

package isa_pkg;

  // Base opcodes found in the low seven bits of a word
  typedef enum logic [6:0] {
    OPC_LOAD    = 7'h03,
    OPC_BIGNUM  = 7'h0b,
    OPC_OP_IMM  = 7'h13,
    OPC_STORE   = 7'h23,
    OPC_BN_ALU  = 7'h2b,
    OPC_OP      = 7'h33,
    OPC_LUI     = 7'h37,
    OPC_BRANCH  = 7'h63,
    OPC_JALR    = 7'h67,
    OPC_JAL     = 7'h6f,
    OPC_SYSTEM  = 7'h73,
    OPC_BN_MAC  = 7'h7b
  } opcode_e;

  // Plain instruction as seen by the decoder
  typedef logic [`INSN_W-1:0] insn_t;

  // Check bits kept with every word
  typedef logic [`INTG_W-1:0] intg_t;

  // Word as stored in memory, check bits sit above the instruction
  typedef logic [`INSN_INTG_W-1:0] insn_intg_t;

endpackage

// File: common/fetch_params.svh
//////////////////////////////////////////////////
// Instruction fetch parameters
// Memory geometry and stored word layout
//////////////////////////////////////////////////
`ifndef FETCH_PARAMS_SVH
`define FETCH_PARAMS_SVH

// Instruction memory size in bytes
`define IMEM_SIZE_BYTE 4096

// Byte address width that covers the whole memory
`define IMEM_ADDR_W $clog2(`IMEM_SIZE_BYTE)

// Width of one instruction word
`define INSN_W 32

// Number of check bits stored next to each word
`define INTG_W 7

// Stored word with the check bits above the instruction
`define INSN_INTG_W (`INSN_W + `INTG_W)

`endif
